/* Makefile */
VERILATOR ?= verilator
TOP       ?= qspi_bank_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat list.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/apb_port_decoder.sv */
`timescale 1ns/1ps

module apb_port_decoder import qspi_pkg::*; (
	input  logic                  psel,
	input  logic [APB_ADDR_W-1:0] paddr,
	output logic [N_PORTS-1:0]    port_sel,
	output logic                  decode_err
);

	// Channel number from the bits above the local window
	logic [CHAN_W-1:0] chan;

	assign chan = paddr[APB_ADDR_W-1:LOCAL_ADDR_W];

	// Past the last channel window
	assign decode_err = psel && (chan >= N_PORTS);

	//////////////////////////////////////////////////////////////////////
	// One-hot selects

	always_comb begin
		port_sel = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			// Nothing selected on a decode error
			if (psel && !decode_err && (chan == CHAN_W'(i)))
				port_sel[i] = 1'b1;
		end
	end

endmodule

/* hw/apb_qspi_host.sv */
`timescale 1ns/1ps

module apb_qspi_host import qspi_pkg::*; (
	input  logic                    apb,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [LOCAL_ADDR_W-1:0] paddr,
	input  logic [31:0]             pwdata,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    qspi_sck,
	output logic [3:0]              qspi_dq_out,
	input  logic [3:0]              qspi_dq_in,
	output logic [3:0]              qspi_dq_tris,
	output logic                    qspi_cs_n
);

	//////////////////////////////////////////////////////////////////////
	// Byte shifter

	// Divider minus one
	logic [15:0] clkdiv;
	logic        shift_en;
	logic        quad_shift_en;
	logic [7:0]  shift_data;
	logic        shift_done;
	logic [7:0]  rx_data;
	logic        auto_restart;

	qspi_shifter shifter_i (
		.apb          (apb),
		.rst_n        (rst_n),
		.clkdiv       (clkdiv),
		.shift_en     (shift_en),
		.quad_shift_en(quad_shift_en),
		.auto_restart (auto_restart),
		.tx_data      (shift_data),
		.shift_done   (shift_done),
		.rx_data      (rx_data),
		.qspi_sck     (qspi_sck),
		.qspi_dq_out  (qspi_dq_out),
		.qspi_dq_in   (qspi_dq_in),
		.qspi_dq_tris (qspi_dq_tris)
	);

	//////////////////////////////////////////////////////////////////////
	// Receive buffer

	logic [31:0]             burst_buf [RXBUF_WORDS];
	logic [RXBUF_AW-1:0]     burst_rptr;
	// One extra bit so a full buffer reads as done
	logic [RXBUF_AW:0]       burst_wptr;
	logic [31:0]             burst_wdata;
	logic [31:0]             burst_rdata;
	logic                    burst_wr;
	// Bytes already packed into burst_wdata
	logic [1:0]              burst_wvalid;
	logic [BURST_CNT_W-1:0]  burst_count;
	logic [BURST_CNT_W-1:0]  burst_len;
	logic                    burst_active;
	logic                    shift_busy;
	logic [7:0]              rx_data_ff;
	logic                    reading_rxbuf;
	logic                    filling;
	logic                    stall;
	logic                    busy_flag;

	assign burst_rptr    = paddr[RXBUF_AW+1:2];
	assign burst_rdata   = burst_buf[burst_rptr];
	assign reading_rxbuf = (paddr >= REG_BURST_RXBUF);
	// Still filling until the last word lands
	assign filling       = burst_active || burst_wr;
	assign busy_flag     = shift_busy || filling;
	assign auto_restart  = burst_active && (burst_count > 1);

	// Requested length, clamped
	assign burst_len = (pwdata > BURST_MAX) ? BURST_CNT_W'(BURST_MAX) :
		pwdata[BURST_CNT_W-1:0];

	// Hold the bus while the word is not there yet
	always_comb begin
		stall = 1'b0;
		if (psel && penable && !pwrite && reading_rxbuf && filling) begin
			if ({1'b0, burst_rptr} > burst_wptr)
				stall = 1'b1;
			// Same word, ok only if written this cycle
			if (({1'b0, burst_rptr} == burst_wptr) && !burst_wr)
				stall = 1'b1;
		end
	end

	assign pready = psel && penable && !stall;

	//////////////////////////////////////////////////////////////////////
	// Register decode

	always_comb begin
		prdata        = '0;
		pslverr       = 1'b0;
		shift_en      = 1'b0;
		quad_shift_en = 1'b0;
		shift_data    = '0;
		if (pready && pwrite) begin
			case (paddr)
				REG_DATA: begin
					shift_en   = 1'b1;
					shift_data = pwdata[7:0];
				end
				// Sequential only
				REG_CLK_DIV, REG_CS_N: begin
				end
				// Burst sends 0x00 and starts the first byte
				REG_BURST_RDLEN:  shift_en      = 1'b1;
				REG_QBURST_RDLEN: quad_shift_en = 1'b1;
				default:          pslverr       = 1'b1;
			endcase
		end else if (pready) begin
			if (reading_rxbuf) begin
				// Forward a word written this very cycle
				if (burst_wr && (burst_wptr == {1'b0, burst_rptr}))
					prdata = burst_wdata;
				else
					prdata = burst_rdata;
			end else begin
				case (paddr)
					REG_CLK_DIV:  prdata = {16'h0, clkdiv + 16'd1};
					REG_DATA:     prdata = {24'h0, rx_data_ff};
					REG_CS_N:     prdata = {31'h0, qspi_cs_n};
					REG_STATUS:   prdata = {31'h0, busy_flag};
					REG_STATUS_2: prdata = {31'h0, busy_flag};
					REG_QUAD_CAP: prdata = 32'h1;
					default:      pslverr = 1'b1;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Control state and burst sequencer

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			qspi_cs_n    <= 1'b1;
			clkdiv       <= 16'(CLKDIV_RESET - 1);
			shift_busy   <= 1'b0;
			burst_active <= 1'b0;
			burst_count  <= '0;
			burst_wr     <= 1'b0;
			burst_wvalid <= '0;
			burst_wptr   <= '0;
			rx_data_ff   <= '0;
		end else begin
			burst_wr <= 1'b0;
			if (shift_en)
				shift_busy <= 1'b1;
			if (shift_done) begin
				shift_busy <= 1'b0;
				rx_data_ff <= rx_data;
			end
			if (burst_wr)
				burst_wptr <= burst_wptr + 1'b1;

			if (pready && pwrite) begin
				case (paddr)
					REG_CS_N:    qspi_cs_n <= pwdata[0];
					REG_CLK_DIV: clkdiv    <= pwdata[15:0] - 16'd1;
					REG_BURST_RDLEN, REG_QBURST_RDLEN: begin
						burst_active <= 1'b1;
						burst_count  <= burst_len;
						burst_wptr   <= '0;
						burst_wvalid <= '0;
					end
					default: begin
					end
				endcase
			end

			// One byte in, flush on a full word or the last byte
			if (burst_active && shift_done) begin
				burst_count  <= burst_count - 1'b1;
				burst_wvalid <= burst_wvalid + 2'd1;
				if ((burst_wvalid == 2'd3) || (burst_count <= 1))
					burst_wr <= 1'b1;
				if (burst_count <= 1)
					burst_active <= 1'b0;
			end
		end
	end

	// Little endian packing, then buffer write
	always_ff @(posedge apb) begin
		if (burst_active && shift_done) begin
			case (burst_wvalid)
				2'd0: burst_wdata        <= {24'h0, rx_data};
				2'd1: burst_wdata[15:8]  <= rx_data;
				2'd2: burst_wdata[23:16] <= rx_data;
				2'd3: burst_wdata[31:24] <= rx_data;
			endcase
		end
		if (burst_wr)
			burst_buf[burst_wptr[RXBUF_AW-1:0]] <= burst_wdata;
	end

endmodule

/* hw/apb_response_merge.sv */
`timescale 1ns/1ps

module apb_response_merge import qspi_pkg::*; (
	input  logic                     psel,
	input  logic                     penable,
	input  logic [N_PORTS-1:0]       port_sel,
	input  logic                     decode_err,
	input  logic [N_PORTS-1:0][31:0] port_prdata,
	input  logic [N_PORTS-1:0]       port_pready,
	input  logic [N_PORTS-1:0]       port_pslverr,
	output logic [31:0]              prdata,
	output logic                     pready,
	output logic                     pslverr
);

	//////////////////////////////////////////////////////////////////////
	// AND-OR merge

	always_comb begin
		prdata  = '0;
		pready  = 1'b0;
		pslverr = 1'b0;
		for (int i = 0; i < N_PORTS; i++) begin
			prdata  = prdata  | (port_prdata[i] & {32{port_sel[i]}});
			pready  = pready  | (port_pready[i] & port_sel[i]);
			pslverr = pslverr | (port_pslverr[i] & port_sel[i]);
		end
		// No channel answers here, complete with an error
		if (psel && penable && decode_err) begin
			pready  = 1'b1;
			pslverr = 1'b1;
		end
	end

endmodule

/* hw/qspi_bank_top.sv */
`timescale 1ns/1ps

module qspi_bank_top import qspi_pkg::*; (
	input  logic                    apb,
	input  logic                    rst_n,
	input  logic [APB_ADDR_W-1:0]   paddr,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [31:0]             pwdata,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic [N_PORTS-1:0]      qspi_sck,
	output logic [N_PORTS-1:0][3:0] qspi_dq_out,
	input  logic [N_PORTS-1:0][3:0] qspi_dq_in,
	output logic [N_PORTS-1:0][3:0] qspi_dq_tris,
	output logic [N_PORTS-1:0]      qspi_cs_n
);

	logic [N_PORTS-1:0]       port_sel;
	logic                     decode_err;
	logic [N_PORTS-1:0][31:0] port_prdata;
	logic [N_PORTS-1:0]       port_pready;
	logic [N_PORTS-1:0]       port_pslverr;

	//////////////////////////////////////////////////////////////////////
	// Address decode

	apb_port_decoder decoder_i (
		.psel      (psel),
		.paddr     (paddr),
		.port_sel  (port_sel),
		.decode_err(decode_err)
	);

	//////////////////////////////////////////////////////////////////////
	// Channels

	for (genvar i = 0; i < N_PORTS; i++) begin : g_chan
		// Each channel sees only its local offset
		apb_qspi_host host_i (
			.apb         (apb),
			.rst_n       (rst_n),
			.psel        (port_sel[i]),
			.penable     (penable),
			.pwrite      (pwrite),
			.paddr       (paddr[LOCAL_ADDR_W-1:0]),
			.pwdata      (pwdata),
			.prdata      (port_prdata[i]),
			.pready      (port_pready[i]),
			.pslverr     (port_pslverr[i]),
			.qspi_sck    (qspi_sck[i]),
			.qspi_dq_out (qspi_dq_out[i]),
			.qspi_dq_in  (qspi_dq_in[i]),
			.qspi_dq_tris(qspi_dq_tris[i]),
			.qspi_cs_n   (qspi_cs_n[i])
		);
	end

	// Response back to the bus
	apb_response_merge merge_i (
		.psel        (psel),
		.penable     (penable),
		.port_sel    (port_sel),
		.decode_err  (decode_err),
		.port_prdata (port_prdata),
		.port_pready (port_pready),
		.port_pslverr(port_pslverr),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr)
	);

endmodule

/* hw/qspi_pkg.sv */
package qspi_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bank geometry

	// Channels on the shared APB bus
	localparam int unsigned N_PORTS      = 4;

	// Global address, top bits pick the channel
	localparam int unsigned APB_ADDR_W   = 12;
	localparam int unsigned LOCAL_ADDR_W = 9;
	localparam int unsigned CHAN_W       = APB_ADDR_W - LOCAL_ADDR_W;

	//////////////////////////////////////////////////////////////////////
	// Channel register map

	// Registers on 0x20 boundaries
	localparam logic [LOCAL_ADDR_W-1:0] REG_CLK_DIV      = 9'h000;
	localparam logic [LOCAL_ADDR_W-1:0] REG_DATA         = 9'h020;
	localparam logic [LOCAL_ADDR_W-1:0] REG_CS_N         = 9'h040;
	localparam logic [LOCAL_ADDR_W-1:0] REG_STATUS       = 9'h060;
	// Same busy flag as REG_STATUS
	localparam logic [LOCAL_ADDR_W-1:0] REG_STATUS_2     = 9'h080;
	localparam logic [LOCAL_ADDR_W-1:0] REG_BURST_RDLEN  = 9'h0a0;
	localparam logic [LOCAL_ADDR_W-1:0] REG_QUAD_CAP     = 9'h0c0;
	localparam logic [LOCAL_ADDR_W-1:0] REG_QBURST_RDLEN = 9'h0e0;
	// Receive window, everything from here up
	localparam logic [LOCAL_ADDR_W-1:0] REG_BURST_RXBUF  = 9'h100;

	//////////////////////////////////////////////////////////////////////
	// Reset values and burst limits

	// PCLK cycles per SCK half period out of reset
	localparam int unsigned CLKDIV_RESET = 100;

	// Longest burst in bytes, and the buffer that holds it
	localparam int unsigned BURST_MAX    = 256;
	localparam int unsigned BURST_CNT_W  = $clog2(BURST_MAX) + 1;
	localparam int unsigned RXBUF_WORDS  = 64;
	localparam int unsigned RXBUF_AW     = $clog2(RXBUF_WORDS);

endpackage

/* hw/qspi_shifter.sv */
`timescale 1ns/1ps

module qspi_shifter (
	input  logic        apb,
	input  logic        rst_n,
	input  logic [15:0] clkdiv,
	input  logic        shift_en,
	input  logic        quad_shift_en,
	input  logic        auto_restart,
	input  logic [7:0]  tx_data,
	output logic        shift_done,
	output logic [7:0]  rx_data,
	output logic        qspi_sck,
	output logic [3:0]  qspi_dq_out,
	input  logic [3:0]  qspi_dq_in,
	output logic [3:0]  qspi_dq_tris
);

	// Byte in progress
	logic        busy;
	// Mode of the current byte, kept for restarts
	logic        quad;
	// Cycles into the current half period
	logic [15:0] div_count;
	// Half periods left after the current one
	logic [3:0]  half_left;
	logic [7:0]  tx_sr;
	logic [7:0]  rx_sr;
	logic        start;

	// New command, or back to back burst byte
	assign start = shift_en || quad_shift_en || (shift_done && auto_restart);

	//////////////////////////////////////////////////////////////////////
	// Divider and edge sequencing

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			quad       <= 1'b0;
			qspi_sck   <= 1'b0;
			div_count  <= '0;
			half_left  <= '0;
			tx_sr      <= '0;
			rx_sr      <= '0;
			shift_done <= 1'b0;
		end else begin
			shift_done <= 1'b0;
			if (start) begin
				busy      <= 1'b1;
				div_count <= '0;
				tx_sr     <= tx_data;
				// Restart keeps the latched mode
				if (shift_en || quad_shift_en)
					quad <= quad_shift_en;
				// 16 half periods single, 4 quad
				if (shift_en || (!quad_shift_en && !quad))
					half_left <= 4'd15;
				else
					half_left <= 4'd3;
			end else if (busy) begin
				if (div_count == clkdiv) begin
					div_count <= '0;
					qspi_sck  <= !qspi_sck;
					// Rising edge, sample
					if (!qspi_sck) begin
						if (quad)
							rx_sr <= {rx_sr[3:0], qspi_dq_in};
						else
							rx_sr <= {rx_sr[6:0], qspi_dq_in[1]};
					end
					// Falling edge, next bit out
					else
						tx_sr <= {tx_sr[6:0], 1'b0};
					// Last falling edge ends the byte
					if (half_left == 4'd0) begin
						busy       <= 1'b0;
						shift_done <= 1'b1;
					end else
						half_left <= half_left - 4'd1;
				end else
					div_count <= div_count + 16'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pin drive

	assign rx_data = rx_sr;

	// MSB first on dq0, quad reads drive nothing
	assign qspi_dq_out  = quad ? 4'b0000 : {3'b000, tx_sr[7]};
	assign qspi_dq_tris = (busy && !quad) ? 4'b1110 : 4'b1111;

endmodule

/* list.f */
hw/qspi_pkg.sv
hw/qspi_shifter.sv
hw/apb_qspi_host.sv
hw/apb_port_decoder.sv
hw/apb_response_merge.sv
hw/qspi_bank_top.sv
sim/tb_clock.sv
sim/qspi_flash_model.sv
sim/qspi_bank_assertions.sv
sim/qspi_bank_tb.sv

/* sim/qspi_bank_assertions.sv */
`timescale 1ns/1ps

module qspi_bank_assertions import qspi_pkg::*; (
	input logic                    apb,
	input logic                    rst_n,
	input logic                    psel,
	input logic                    penable,
	input logic                    pwrite,
	input logic                    pready,
	input logic [N_PORTS-1:0]      qspi_sck,
	input logic [N_PORTS-1:0]      qspi_cs_n,
	input logic [N_PORTS-1:0][3:0] qspi_dq_tris
);

	// pready only in the access phase
	a_pready_access: assert property (@(posedge apb) disable iff (!rst_n)
		pready |-> (psel && penable))
		else $error("pready high outside the APB access phase");

	//////////////////////////////////////////////////////////////////////
	// Per channel pin checks

	for (genvar i = 0; i < N_PORTS; i++) begin : g_chan
		// cs_n moves only on a completed write
		a_cs_write: assert property (@(posedge apb) disable iff (!rst_n)
			!$stable(qspi_cs_n[i]) |-> $past(psel && penable && pready && pwrite))
			else $error("cs_n changed without an APB write on channel %0d", i);

		// Deselected channel keeps SCK low
		a_sck_idle: assert property (@(posedge apb) disable iff (!rst_n)
			qspi_cs_n[i] |-> !qspi_sck[i])
			else $error("SCK high while channel %0d is idle", i);

		// dq0 released while clocking means a quad read
		a_quad_tris: assert property (@(posedge apb) disable iff (!rst_n)
			(qspi_sck[i] && qspi_dq_tris[i][0]) |-> (qspi_dq_tris[i] == 4'hf))
			else $error("quad shift on channel %0d drives a data line", i);
	end

endmodule

/* sim/qspi_bank_tb.sv */
`timescale 1ns/1ps

module qspi_bank_tb import qspi_pkg::*; ();

	localparam int unsigned TIMEOUT_CYCLES = 20000;

	logic                     apb;
	logic                     rst_n;
	logic [APB_ADDR_W-1:0]    paddr;
	logic                     psel;
	logic                     penable;
	logic                     pwrite;
	logic [31:0]              pwdata;
	logic [31:0]              prdata;
	logic                     pready;
	logic                     pslverr;
	logic [N_PORTS-1:0]       qspi_sck;
	logic [N_PORTS-1:0][3:0]  qspi_dq_out;
	wire  [N_PORTS-1:0][3:0]  qspi_dq_in;
	logic [N_PORTS-1:0][3:0]  qspi_dq_tris;
	logic [N_PORTS-1:0]       qspi_cs_n;
	// Flash read mode per channel
	logic [N_PORTS-1:0]       quad_mode;
	// Bits seen on dq0 at each rising SCK
	logic [N_PORTS-1:0][7:0]  tx_seen;
	logic [N_PORTS-1:0]       sck_prev;

	logic [31:0]              lfsr_state;
	int unsigned              mismatches;
	int unsigned              failures;
	// Longest pready wait seen
	int unsigned              max_waits;

	tb_clock clock_i (
		.apb  (apb),
		.rst_n(rst_n)
	);

	qspi_bank_top qspi_bank_top_i (
		.apb         (apb),
		.rst_n       (rst_n),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.qspi_sck    (qspi_sck),
		.qspi_dq_out (qspi_dq_out),
		.qspi_dq_in  (qspi_dq_in),
		.qspi_dq_tris(qspi_dq_tris),
		.qspi_cs_n   (qspi_cs_n)
	);

	for (genvar i = 0; i < N_PORTS; i++) begin : g_flash
		qspi_flash_model #(.CHAN(i)) flash_i (
			.cs_n(qspi_cs_n[i]),
			.sck (qspi_sck[i]),
			.quad(quad_mode[i]),
			.dq  (qspi_dq_in[i])
		);
	end

	bind qspi_bank_top qspi_bank_assertions assertions_i (
		.apb         (apb),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pready      (pready),
		.qspi_sck    (qspi_sck),
		.qspi_cs_n   (qspi_cs_n),
		.qspi_dq_tris(qspi_dq_tris)
	);

	// Host data on dq0 taken mid cycle after each rising SCK
	always @(negedge apb) begin
		for (int i = 0; i < N_PORTS; i++) begin
			if (qspi_sck[i] && !sck_prev[i])
				tx_seen[i] <= {tx_seen[i][6:0], qspi_dq_out[i][0]};
		end
		sck_prev <= qspi_sck;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and helpers

	// Flash byte k of a selection on one channel
	function automatic logic [7:0] expected_byte(int unsigned chan, int unsigned k);
		return 8'((k * 37 + 11 + 64 * chan) % 256);
	endfunction

	function automatic logic [APB_ADDR_W-1:0] chan_addr(int unsigned chan,
		logic [LOCAL_ADDR_W-1:0] offset);
		return {CHAN_W'(chan), offset};
	endfunction

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit
	task automatic take_bits(input int unsigned n, output int unsigned v);
		v = 0;
		for (int unsigned i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | 32'(lfsr_state[0]);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_and_finish();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if ((mismatches == 0) && (failures == 0))
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	task automatic timeout_fail(input string what);
		failures++;
		$display("timeout: %s", what);
		report_and_finish();
	endtask

	//////////////////////////////////////////////////////////////////////
	// APB access

	task automatic apb_access(input logic [APB_ADDR_W-1:0] addr, input logic write,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int unsigned cycles;
		logic        done;
		cycles  = 0;
		done    = 1'b0;
		rdata   = '0;
		err     = 1'b0;
		// Setup phase
		paddr   = addr;
		pwrite  = write;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge apb);
		check_value("pready", 32'(pready), 32'h0);
		@(posedge apb);
		#1;
		penable = 1'b1;
		// Access phase sampled mid cycle
		while (!done) begin
			@(negedge apb);
			if (pready) begin
				rdata = prdata;
				err   = pslverr;
				done  = 1'b1;
			end else begin
				if (cycles >= TIMEOUT_CYCLES)
					timeout_fail("pready stayed low in the access phase");
				cycles++;
			end
			@(posedge apb);
			#1;
		end
		if (cycles > max_waits)
			max_waits = cycles;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] unused_rd;
		logic        err;
		apb_access(addr, 1'b1, data, unused_rd, err);
		check_value("pslverr", 32'(err), 32'h0);
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
		logic err;
		apb_access(addr, 1'b0, '0, data, err);
		check_value("pslverr", 32'(err), 32'h0);
	endtask

	task automatic read_check(input int unsigned chan, input logic [LOCAL_ADDR_W-1:0] offset,
		input string name, input logic [31:0] exp);
		logic [31:0] got;
		apb_read(chan_addr(chan, offset), got);
		check_value($sformatf("ch%0d %s", chan, name), got, exp);
	endtask

	// Poll STATUS until the channel is idle
	task automatic wait_idle(input int unsigned chan);
		logic [31:0] st;
		int unsigned polls;
		polls = 0;
		apb_read(chan_addr(chan, REG_STATUS), st);
		while (st[0]) begin
			if (polls >= TIMEOUT_CYCLES)
				timeout_fail($sformatf("STATUS of channel %0d stayed busy", chan));
			polls++;
			apb_read(chan_addr(chan, REG_STATUS), st);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Burst sequences

	task automatic run_burst(input int unsigned chan, input logic quad,
		input int unsigned len, input int unsigned div, input logic read_now);
		quad_mode[chan] = quad;
		apb_write(chan_addr(chan, REG_CLK_DIV), div);
		// Fresh selection restarts the flash byte count
		apb_write(chan_addr(chan, REG_CS_N), 32'h1);
		apb_write(chan_addr(chan, REG_CS_N), 32'h0);
		apb_write(chan_addr(chan, quad ? REG_QBURST_RDLEN : REG_BURST_RDLEN), len);
		if (!read_now)
			wait_idle(chan);
	endtask

	// Little endian words with the partial last word masked
	task automatic check_words(input int unsigned chan, input int unsigned len,
		input int unsigned first);
		logic [31:0] got;
		logic [31:0] exp;
		logic [31:0] mask;
		for (int unsigned w = first; w < (len + 3) / 4; w++) begin
			exp  = '0;
			mask = '0;
			for (int unsigned b = 0; b < 4; b++) begin
				if (4 * w + b < len) begin
					exp[8*b +: 8]  = expected_byte(chan, 4 * w + b);
					mask[8*b +: 8] = 8'hff;
				end
			end
			apb_read(chan_addr(chan, REG_BURST_RXBUF + LOCAL_ADDR_W'(4 * w)), got);
			check_value($sformatf("ch%0d rxbuf[%0d]", chan, w), got & mask, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [31:0]        rd;
		logic               err;
		logic [N_PORTS-1:0] exp_cs;
		int unsigned        chan;
		int unsigned        chan_b;
		int unsigned        len;
		int unsigned        div;
		int unsigned        div_b;
		int unsigned        data;
		int unsigned        cycles;
		paddr      = '0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = '0;
		quad_mode  = '0;
		lfsr_state = 32'h1cb9;
		mismatches = 0;
		failures   = 0;
		max_waits  = 0;
		cycles     = 0;
		while (rst_n !== 1'b1) begin
			if (cycles >= TIMEOUT_CYCLES)
				timeout_fail("reset never released");
			cycles++;
			@(posedge apb);
		end
		@(posedge apb);
		#1;

		// Reset values on every channel
		for (int unsigned c = 0; c < N_PORTS; c++) begin
			read_check(c, REG_CLK_DIV, "CLK_DIV", CLKDIV_RESET);
			read_check(c, REG_CS_N, "CS_N", 32'h1);
			read_check(c, REG_STATUS, "STATUS", 32'h0);
			read_check(c, REG_STATUS_2, "STATUS_2", 32'h0);
			read_check(c, REG_QUAD_CAP, "QUAD_CAP", 32'h1);
		end
		check_value("qspi_cs_n", 32'(qspi_cs_n), 32'((N_PORTS)'('1)));

		// Single byte shifts under one selection
		take_bits(2, chan);
		apb_write(chan_addr(chan, REG_CLK_DIV), 32'd2);
		apb_write(chan_addr(chan, REG_CS_N), 32'h0);
		exp_cs       = '1;
		exp_cs[chan] = 1'b0;
		check_value("qspi_cs_n", 32'(qspi_cs_n), 32'(exp_cs));
		for (int unsigned k = 0; k < 2; k++) begin
			take_bits(8, data);
			apb_write(chan_addr(chan, REG_DATA), data);
			wait_idle(chan);
			read_check(chan, REG_DATA, "DATA", 32'(expected_byte(chan, k)));
			// Written byte goes out MSB first on dq0
			check_value($sformatf("ch%0d dq0", chan), 32'(tx_seen[chan]), 32'(data[7:0]));
		end
		apb_write(chan_addr(chan, REG_CS_N), 32'h1);
		check_value("qspi_cs_n", 32'(qspi_cs_n), 32'((N_PORTS)'('1)));

		// Single mode burst of random length
		take_bits(2, chan);
		take_bits(6, len);
		len = len + 1;
		take_bits(2, div);
		div = div + 1;
		run_burst(chan, 1'b0, len, div, 1'b0);
		check_words(chan, len, 0);

		// Quad burst read while it fills
		take_bits(2, chan);
		take_bits(1, chan_b);
		chan_b = (chan + 1 + chan_b) % N_PORTS;
		take_bits(5, len);
		len = len + 8;
		take_bits(2, div);
		div = div + 2;
		take_bits(2, div_b);
		div_b     = div + 1 + div_b;
		max_waits = 0;
		run_burst(chan, 1'b1, len, div, 1'b1);
		check_words(chan, len, 0);
		if (max_waits == 0) begin
			failures++;
			$display("receive window read on channel %0d was never stalled", chan);
		end
		wait_idle(chan);
		run_burst(chan_b, 1'b1, len, div_b, 1'b1);
		check_words(chan_b, len, 0);
		wait_idle(chan_b);

		// Length past BURST_MAX is clamped
		take_bits(2, chan);
		run_burst(chan, 1'b1, 300, 1, 1'b1);
		check_words(chan, BURST_MAX, RXBUF_WORDS - 1);
		// Busy drops once word 63 is stored
		read_check(chan, REG_STATUS, "STATUS", 32'h0);

		// Error completions
		apb_access(chan_addr(0, 9'h010), 1'b0, '0, rd, err);
		check_value("pslverr unmapped read", 32'(err), 32'h1);
		apb_access(chan_addr(1, REG_QUAD_CAP), 1'b1, 32'h5, rd, err);
		check_value("pslverr read-only write", 32'(err), 32'h1);
		apb_access(12'h800, 1'b0, '0, rd, err);
		check_value("pslverr decode", 32'(err), 32'h1);

		report_and_finish();
	end

endmodule

/* sim/qspi_flash_model.sv */
`timescale 1ns/1ps

module qspi_flash_model #(
	parameter int unsigned CHAN = 0
) (
	input  logic       cs_n,
	input  logic       sck,
	input  logic       quad,
	output logic [3:0] dq
);

	// Every falling SCK edge ever seen
	int unsigned fall_count = 0;
	// Edge count at the last falling cs_n
	int unsigned sel_start = 0;
	// Edges into the current selection
	int unsigned pos;
	int unsigned byte_idx;
	logic [7:0]  cur_byte;

	// Byte k of a selection
	function automatic logic [7:0] pattern_byte(int unsigned k);
		return 8'((k * 37 + 11 + 64 * CHAN) % 256);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Edge tracking

	always @(negedge sck)
		fall_count <= fall_count + 1;

	// New selection restarts at byte 0
	always @(negedge cs_n)
		sel_start <= fall_count;

	//////////////////////////////////////////////////////////////////////
	// Mode 0 output, changes after each falling edge

	always_comb begin
		pos = fall_count - sel_start;
		if (quad) begin
			// Two nibbles per byte, high first
			byte_idx = pos >> 1;
			cur_byte = pattern_byte(byte_idx);
			dq       = pos[0] ? cur_byte[3:0] : cur_byte[7:4];
		end else begin
			// MSB first on dq1
			byte_idx = pos >> 3;
			cur_byte = pattern_byte(byte_idx);
			dq       = {2'b00, cur_byte[~pos[2:0]], 1'b0};
		end
	end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic apb,
	output logic rst_n
);

	// 4 ns period
	initial begin
		apb = 1'b0;
		forever #2 apb = !apb;
	end

	// Reset held for three rising edges, released off the edge
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge apb);
		#1;
		rst_n = 1'b1;
	end

endmodule
